// File: Makefile
TOP := bcp_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
+incdir+hw
hw/sat_lit_pkg.sv
hw/bcp_ctrl_pkg.sv
hw/var_bus_if.sv
hw/lit_cell.sv
hw/clause_row.sv
hw/var_table.sv
hw/bcp_ctrl.sv
hw/bcp_top.sv
verification/tb_clock.sv
verification/bcp_tb.sv

// File: hw/bcp_ctrl.sv
`timescale 1ns/10ps

module bcp_ctrl
    import bcp_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     decide_i,
    input  var_idx_t decide_var_i,
    input  logic     decide_val_i,
    var_bus_if.ctrl  bus,
    output logic     cclause_drv_o,
    output logic     done_o,
    output logic     conflict_o
);

    bcp_state_t state_r;
    bcp_state_t state_nxt;
    var_idx_t   dec_var_r;
    logic       dec_val_r;
    logic       fail_r;
    logic       start;
    logic       fail;
    logic       stop;

    assign start = (state_r == IDLE) && decide_i;
    assign fail = bus.conflict || bus.false_any;
    assign stop = !bus.changed || fail;

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            IDLE:      if (decide_i) state_nxt = DECIDE;
            DECIDE:    state_nxt = PROPAGATE;
            PROPAGATE: if (stop) state_nxt = fail ? MARK : FINISH;
            MARK:      state_nxt = FINISH;
            FINISH:    state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_r <= IDLE;
        end else begin
            state_r <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dec_var_r <= decide_var_i;
            dec_val_r <= decide_val_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            fail_r <= 1'b0;
        end else if (start) begin
            fail_r <= 1'b0;
        end else if (state_r == PROPAGATE && stop && fail) begin
            fail_r <= 1'b1;
        end
    end

    assign bus.dec_en = (state_r == DECIDE);
    assign bus.dec_var = dec_var_r;
    assign bus.dec_val = dec_val_r;
    assign bus.round_en = (state_r == PROPAGATE);
    assign bus.mark_en = (state_r == MARK);
    assign cclause_drv_o = (state_r == MARK);

    assign done_o = (state_r == FINISH);
    assign conflict_o = fail_r && (state_r == FINISH || state_r == IDLE);

    // a unit row always finds a free column, so the table must move.
    a_unit_moves : assert property (@(posedge clk) disable iff (!rst)
        (bus.round_en && bus.unit_any) |-> bus.changed);

    a_cclause_has_conflict : assert property (@(posedge clk) disable iff (!rst)
        bus.cclause_any |-> bus.conflict);

endmodule

// File: hw/bcp_ctrl_pkg.sv
`include "bcp_macros.svh"

package bcp_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        DECIDE,
        PROPAGATE,
        MARK,
        FINISH
    } bcp_state_t;

    // selects the variable a host decision applies to.
    typedef logic [$clog2(`N_VARS)-1:0] var_idx_t;

endpackage

// File: hw/bcp_macros.svh
`ifndef BCP_MACROS_SVH
`define BCP_MACROS_SVH

// #####################################################################
// matrix size
// #####################################################################

`define N_VARS 4        // one column per variable.
`define N_CLAUSES 4     // one row per clause.
`define CLAUSE_IDX_W 2  // wide enough to address every row.

`endif

// File: hw/bcp_top.sv
`timescale 1ns/10ps
`include "bcp_macros.svh"

module bcp_top
    import sat_lit_pkg::*, bcp_ctrl_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      clause_wr_i,
    input  logic [`CLAUSE_IDX_W-1:0]  clause_idx_i,
    input  lit_code_t [`N_VARS-1:0]   clause_lits_i,
    input  logic                      decide_i,
    input  var_idx_t                  decide_var_i,
    input  logic                      decide_val_i,
    output logic                      done_o,
    output logic                      conflict_o,
    output var_val_t [`N_VARS-1:0]    assign_o,
    output logic [`N_VARS-1:0]        conflict_vars_o
);

    logic cclause_drv;

    var_bus_if bus ();

    genvar g;
    generate
        for (g = 0; g < `N_CLAUSES; g++) begin : g_row
            clause_row #(
                .ROW_IDX (g)
            ) u_row (
                .clk           (clk),
                .rst           (rst),
                .wr_i          (clause_wr_i && (int'(clause_idx_i) == g)),
                .lits_i        (clause_lits_i),
                .cclause_drv_i (cclause_drv),
                .bus           (bus.rows),
                .unit_o        (bus.row_unit[g]),
                .false_o       (bus.row_false[g]),
                .cclause_o     (bus.row_cclause[g])
            );
        end
    endgenerate

    var_table u_table (
        .clk             (clk),
        .rst             (rst),
        .bus             (bus.tbl),
        .assign_o        (assign_o),
        .conflict_vars_o (conflict_vars_o)
    );

    bcp_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .decide_i      (decide_i),
        .decide_var_i  (decide_var_i),
        .decide_val_i  (decide_val_i),
        .bus           (bus.ctrl),
        .cclause_drv_o (cclause_drv),
        .done_o        (done_o),
        .conflict_o    (conflict_o)
    );

endmodule

// File: hw/clause_row.sv
`timescale 1ns/10ps
`include "bcp_macros.svh"

module clause_row
    import sat_lit_pkg::*;
#(
    parameter int ROW_IDX = 0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_i,
    input  lit_code_t [`N_VARS-1:0] lits_i,
    input  logic                    cclause_drv_i,
    var_bus_if.rows                 bus,
    output logic                    unit_o,
    output logic                    false_o,
    output logic                    cclause_o
);

    free_cnt_t [`N_VARS:0]   cnt;
    lit_code_t [`N_VARS-1:0] lit_q;
    logic [`N_VARS-1:0]      sat_v;
    logic [`N_VARS-1:0]      ccl_v;
    logic                    satisfied;
    logic                    imp_drv;
    logic                    mark_drv;

    assign cnt[0] = CNT_NONE;

    genvar g;
    generate
        for (g = 0; g < `N_VARS; g++) begin : g_cell
            lit_cell u_cell (
                .clk             (clk),
                .rst             (rst),
                .var_value_i     (bus.cur_val[g]),
                .var_value_o     (bus.row_val[ROW_IDX][g]),
                .wr_i            (wr_i),
                .lit_i           (lits_i[g]),
                .lit_o           (lit_q[g]),
                .freelitcnt_pre  (cnt[g]),
                .freelitcnt_next (cnt[g+1]),
                .imp_drv_i       (imp_drv),
                .cclause_o       (ccl_v[g]),
                .cclause_drv_i   (mark_drv),
                .clausesat_o     (sat_v[g])
            );
        end
    endgenerate

    assign satisfied = |sat_v;
    assign unit_o = (cnt[`N_VARS] == CNT_ONE) && !satisfied;
    assign false_o = (|lit_q) && (cnt[`N_VARS] == CNT_NONE) && !satisfied;
    assign cclause_o = |ccl_v;

    assign imp_drv = unit_o && bus.round_en;     // implications only land inside a round.
    assign mark_drv = cclause_drv_i && cclause_o;

    a_unit_not_false : assert property (@(posedge clk) disable iff (!rst)
        !(unit_o && false_o));

endmodule

// File: hw/lit_cell.sv
`timescale 1ns/10ps

module lit_cell
    import sat_lit_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  var_val_t  var_value_i,
    output var_val_t  var_value_o,

    input  logic      wr_i,
    input  lit_code_t lit_i,
    output lit_code_t lit_o,

    input  free_cnt_t freelitcnt_pre,
    output free_cnt_t freelitcnt_next,

    input  logic      imp_drv_i,

    output logic      cclause_o,
    input  logic      cclause_drv_i,

    output logic      clausesat_o
);

    lit_code_t lit_r;
    logic      implied_r;
    logic      participate;
    logic      isfree;
    logic      drive_imp;

    assign participate = (lit_r != LIT_ABSENT);
    assign isfree = (var_value_i[2:1] == POL_FREE);
    assign drive_imp = participate && isfree && imp_drv_i;

    assign clausesat_o = participate && (lit_r == var_value_i[2:1]);
    assign cclause_o = participate && implied_r && (var_value_i[2:1] == POL_CONFLICT);
    assign lit_o = lit_r;

    always_comb begin
        if (participate && isfree) begin
            freelitcnt_next = (freelitcnt_pre == CNT_NONE) ? CNT_ONE : CNT_MANY;
        end else begin
            freelitcnt_next = freelitcnt_pre;
        end
    end

    // the literal code doubles as the polarity it forces.
    always_comb begin
        if (drive_imp) begin
            var_value_o = {lit_r, 1'b1};
        end else if (participate && cclause_drv_i) begin
            var_value_o = {POL_CONFLICT, implied_r};
        end else begin
            var_value_o = {POL_FREE, implied_r};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            implied_r <= 1'b0;
        end else if (drive_imp) begin
            implied_r <= 1'b1;  // sticky until the next formula.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            lit_r <= LIT_ABSENT;
        end else if (wr_i) begin
            lit_r <= lit_i;
        end
    end

    // an implying cell is the only free literal of its row.
    a_first_free : assert property (@(posedge clk) disable iff (!rst)
        drive_imp |-> (freelitcnt_pre == CNT_NONE && freelitcnt_next == CNT_ONE));

endmodule

// File: hw/sat_lit_pkg.sv
package sat_lit_pkg;

    // literal held by a clause on one variable.
    typedef logic [1:0] lit_code_t;

    // polarity in the upper two bits, implied flag in bit 0.
    typedef logic [2:0] var_val_t;

    // saturating count of free literals along a row.
    typedef logic [1:0] free_cnt_t;

    localparam lit_code_t LIT_ABSENT = 2'b00;
    localparam lit_code_t LIT_POS = 2'b10;
    localparam lit_code_t LIT_NEG = 2'b01;

    localparam logic [1:0] POL_FREE = 2'b00;
    localparam logic [1:0] POL_TRUE = 2'b10;
    localparam logic [1:0] POL_FALSE = 2'b01;
    localparam logic [1:0] POL_CONFLICT = 2'b11;  // both polarities were driven.

    localparam free_cnt_t CNT_NONE = 2'b00;
    localparam free_cnt_t CNT_ONE = 2'b01;
    localparam free_cnt_t CNT_MANY = 2'b11;

endpackage

// File: hw/var_bus_if.sv
`timescale 1ns/10ps
`include "bcp_macros.svh"

interface var_bus_if
    import sat_lit_pkg::*, bcp_ctrl_pkg::*;
();

    var_val_t [`N_VARS-1:0] cur_val;
    var_val_t [`N_VARS-1:0] row_val [`N_CLAUSES];  // each row fills its own entry.
    var_val_t [`N_VARS-1:0] imp_val;

    logic [`N_CLAUSES-1:0] row_unit;
    logic [`N_CLAUSES-1:0] row_false;
    logic [`N_CLAUSES-1:0] row_cclause;
    logic unit_any;
    logic false_any;
    logic cclause_any;

    logic round_en;
    logic mark_en;
    logic dec_en;
    var_idx_t dec_var;
    logic dec_val;
    logic changed;
    logic conflict;

    // the columns are wired-or across all rows.
    always_comb begin
        imp_val = '0;
        for (int r = 0; r < `N_CLAUSES; r++) begin
            imp_val = imp_val | row_val[r];
        end
    end

    assign unit_any = |row_unit;
    assign false_any = |row_false;
    assign cclause_any = |row_cclause;

    modport tbl (
        input  imp_val, round_en, mark_en, dec_en, dec_var, dec_val,
        output cur_val, changed, conflict
    );

    modport rows (
        input  cur_val, round_en,
        output row_val
    );

    modport ctrl (
        input  unit_any, false_any, cclause_any, changed, conflict,
        output round_en, mark_en, dec_en, dec_var, dec_val
    );

endinterface

// File: hw/var_table.sv
`timescale 1ns/10ps
`include "bcp_macros.svh"

module var_table
    import sat_lit_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    var_bus_if.tbl                 bus,
    output var_val_t [`N_VARS-1:0] assign_o,
    output logic [`N_VARS-1:0]     conflict_vars_o
);

    var_val_t [`N_VARS-1:0] val_r;
    var_val_t [`N_VARS-1:0] next_val;
    logic [`N_VARS-1:0]     mask_r;

    // #####################################################################
    // next value
    // #####################################################################

    always_comb begin
        next_val = val_r;
        for (int v = 0; v < `N_VARS; v++) begin
            if (bus.dec_en && int'(bus.dec_var) == v) begin
                next_val[v][2:1] = next_val[v][2:1] | (bus.dec_val ? POL_TRUE : POL_FALSE);
            end
            if (bus.round_en) begin
                next_val[v] = next_val[v] | bus.imp_val[v];
            end
        end
    end

    always_comb begin
        bus.conflict = 1'b0;
        for (int v = 0; v < `N_VARS; v++) begin
            if (next_val[v][2:1] == POL_CONFLICT) begin
                bus.conflict = 1'b1;
            end
        end
    end

    assign bus.changed = (next_val != val_r);

    // #####################################################################
    // state
    // #####################################################################

    always_ff @(posedge clk) begin
        if (!rst) begin
            val_r <= '0;
        end else begin
            val_r <= next_val;  // holds when neither a decision nor a round is active.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            mask_r <= '0;
        end else if (bus.dec_en) begin
            mask_r <= '0;
        end else if (bus.mark_en) begin
            for (int v = 0; v < `N_VARS; v++) begin
                mask_r[v] <= (bus.imp_val[v][2:1] == POL_CONFLICT);
            end
        end
    end

    assign bus.cur_val = val_r;
    assign assign_o = val_r;
    assign conflict_vars_o = mask_r;

    a_round_xor_mark : assert property (@(posedge clk) disable iff (!rst)
        !(bus.round_en && bus.mark_en));

endmodule

// File: verification/bcp_tb.sv
`timescale 1ns/10ps
`include "bcp_macros.svh"

module bcp_tb
    import sat_lit_pkg::*, bcp_ctrl_pkg::*;
();

    localparam int NV = `N_VARS;
    localparam int NC = `N_CLAUSES;
    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 5;
    localparam int DONE_LIMIT = 40;
    localparam int WATCHDOG_CYCLES = 40 * 40;
    localparam int RANDOM_RUNS = 32;

    typedef lit_code_t [NC-1:0][NV-1:0] formula_t;

    logic                  clk;
    logic                  rst_por;
    logic                  run_rst;
    logic                  rst;
    logic                  clause_wr_i;
    logic [`CLAUSE_IDX_W-1:0] clause_idx_i;
    lit_code_t [NV-1:0]    clause_lits_i;
    logic                  decide_i;
    var_idx_t              decide_var_i;
    logic                  decide_val_i;
    logic                  done_o;
    logic                  conflict_o;
    var_val_t [NV-1:0]     assign_o;
    logic [NV-1:0]         conflict_vars_o;

    var_val_t [NV-1:0]     exp_val;
    logic                  exp_conf;
    logic [NV-1:0]         exp_mask;
    logic                  expect_done;
    int                    n_checked;
    logic [31:0]           rng;
    formula_t              f;

    assign rst = rst_por && run_rst;  // power-on reset combined with the per-run reset.

    tb_clock #(.PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_clock (
        .clk_o (clk),
        .rst_o (rst_por)
    );

    bcp_top dut (
        .clk             (clk),
        .rst             (rst),
        .clause_wr_i     (clause_wr_i),
        .clause_idx_i    (clause_idx_i),
        .clause_lits_i   (clause_lits_i),
        .decide_i        (decide_i),
        .decide_var_i    (decide_var_i),
        .decide_val_i    (decide_val_i),
        .done_o          (done_o),
        .conflict_o      (conflict_o),
        .assign_o        (assign_o),
        .conflict_vars_o (conflict_vars_o)
    );

    // ######################################################################
    // reference model and helpers
    // ######################################################################

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic void bcp_ref(input formula_t fm, input var_idx_t dv, input logic dval,
                                    output var_val_t [NV-1:0] val, output logic confl,
                                    output logic [NV-1:0] cmask);
        logic [NC-1:0][NV-1:0] imp;  // clause c implied variable v.
        var_val_t [NV-1:0]     nxt;
        logic [1:0]            pol;
        logic                  sat;
        logic                  part;
        logic                  falsified;
        logic                  any11;
        logic                  hit;
        int                    nfree;
        int                    fv;
        val = '0;
        imp = '0;
        cmask = '0;
        confl = 1'b0;
        val[dv][2:1] = dval ? 2'b10 : 2'b01;
        for (int round = 0; round < 4 * NV; round++) begin
            nxt = val;
            falsified = 1'b0;
            for (int c = 0; c < NC; c++) begin
                nfree = 0;
                fv = 0;
                sat = 1'b0;
                part = 1'b0;
                for (int v = 0; v < NV; v++) begin
                    pol = val[v][2:1];
                    if (fm[c][v] != 2'b00) begin
                        part = 1'b1;
                        if (pol == 2'b00) begin
                            nfree++;
                            fv = v;
                        end else if (pol == fm[c][v]) begin
                            sat = 1'b1;
                        end
                    end
                end
                if (part && nfree == 0 && !sat) falsified = 1'b1;
                if (nfree == 1 && !sat) begin
                    nxt[fv][2:1] = nxt[fv][2:1] | fm[c][fv];  // opposite literals meet as 11.
                    nxt[fv][0] = 1'b1;
                    imp[c][fv] = 1'b1;
                end
            end
            any11 = 1'b0;
            for (int v = 0; v < NV; v++) begin
                if (nxt[v][2:1] == 2'b11) any11 = 1'b1;
            end
            if (any11 || falsified) begin
                val = nxt;
                confl = 1'b1;
                break;
            end
            if (nxt == val) break;
            val = nxt;
        end
        if (confl) begin
            for (int c = 0; c < NC; c++) begin
                hit = 1'b0;
                for (int v = 0; v < NV; v++) begin
                    if (imp[c][v] && val[v][2:1] == 2'b11) hit = 1'b1;
                end
                for (int v = 0; v < NV; v++) begin
                    if (hit && fm[c][v] != 2'b00) cmask[v] = 1'b1;
                end
            end
        end
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        stop_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic reset_dut();
        run_rst = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        run_rst = 1'b1;
        while (!rst) @(negedge clk);
    endtask

    task automatic load_formula(input formula_t fm);
        for (int c = 0; c < NC; c++) begin
            clause_wr_i = 1'b1;
            clause_idx_i = c[`CLAUSE_IDX_W-1:0];
            clause_lits_i = fm[c];
            @(negedge clk);
        end
        clause_wr_i = 1'b0;
        clause_lits_i = '0;
    endtask

    task automatic wait_for_done(input int seen);
        int cycles;
        cycles = 0;
        while (n_checked == seen) begin
            @(negedge clk);
            cycles++;
            if (cycles > DONE_LIMIT) stop_run("done_o did not arrive after the decision");
        end
    endtask

    task automatic run_formula(input formula_t fm, input var_idx_t dv, input logic dval);
        int seen;
        reset_dut();
        load_formula(fm);
        bcp_ref(fm, dv, dval, exp_val, exp_conf, exp_mask);
        seen = n_checked;
        expect_done = 1'b1;
        decide_i = 1'b1;
        decide_var_i = dv;
        decide_val_i = dval;
        @(negedge clk);
        decide_i = 1'b0;
        wait_for_done(seen);
        expect_done = 1'b0;
    endtask

    // ######################################################################
    // compare, watchdog and stimulus
    // ######################################################################

    initial begin : compare
        forever begin
            @(negedge clk);
            if (done_o) begin
                assert (expect_done) else stop_run("done_o rose without a pending decision");
                assert (assign_o == exp_val)
                    else report_mismatch("assign_o", 16'(assign_o), 16'(exp_val));
                assert (conflict_o == exp_conf)
                    else report_mismatch("conflict_o", 16'(conflict_o), 16'(exp_conf));
                assert (conflict_vars_o == exp_mask)
                    else report_mismatch("conflict_vars_o", 16'(conflict_vars_o), 16'(exp_mask));
                n_checked++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_run("watchdog expired before the tests completed");
    end

    initial begin : stimulus
        run_rst = 1'b1;
        clause_wr_i = 1'b0;
        clause_idx_i = '0;
        clause_lits_i = '0;
        decide_i = 1'b0;
        decide_var_i = '0;
        decide_val_i = 1'b0;
        expect_done = 1'b0;
        n_checked = 0;
        exp_val = '0;
        exp_conf = 1'b0;
        exp_mask = '0;
        rng = 32'd73020;
        while (!rst_por) @(negedge clk);

        // chain x0 -> x1 -> x2 -> !x3, the last clause is satisfied by x0.
        f = {8'b10_00_00_10, 8'b01_01_00_00, 8'b00_10_01_00, 8'b00_00_10_01};
        reset_dut();
        load_formula(f);
        repeat (20) begin
            @(negedge clk);
            assert (done_o == 1'b0) else report_mismatch("done_o", 16'(done_o), 16'd0);
            assert (assign_o == '0) else report_mismatch("assign_o", 16'(assign_o), 16'd0);
        end

        f = {8'h00, 8'b10_01_00_10, 8'b10_10_01_00, 8'b00_10_10_10};
        run_formula(f, 2'd3, 1'b1);
        assert (assign_o == 12'b100_000_000_000)
            else report_mismatch("assign_o", 16'(assign_o), 16'h0800);
        assert (!conflict_o) else report_mismatch("conflict_o", 16'(conflict_o), 16'd0);

        f = {8'b10_00_00_10, 8'b01_01_00_00, 8'b00_10_01_00, 8'b00_00_10_01};
        run_formula(f, 2'd0, 1'b1);
        assert (assign_o == 12'b011_101_101_100)
            else report_mismatch("assign_o", 16'(assign_o), 16'h076c);

        f = {8'h00, 8'b10_10_00_00, 8'b00_00_01_01, 8'b00_00_10_01};
        run_formula(f, 2'd0, 1'b1);
        assert (conflict_o) else report_mismatch("conflict_o", 16'(conflict_o), 16'd1);
        assert (conflict_vars_o == 4'b0011)
            else report_mismatch("conflict_vars_o", 16'(conflict_vars_o), 16'h0003);

        f = {8'h00, 8'h00, 8'b00_10_10_00, 8'b00_00_00_10};
        run_formula(f, 2'd0, 1'b0);  // x0 false leaves the unit clause x0 with no free literal.
        assert (conflict_o) else report_mismatch("conflict_o", 16'(conflict_o), 16'd1);

        for (int run = 0; run < RANDOM_RUNS; run++) begin
            for (int c = 0; c < NC; c++) begin
                rng = xorshift32(rng);
                for (int v = 0; v < NV; v++) begin
                    f[c][v] = (rng[2*v +: 2] == 2'b11) ? LIT_ABSENT : rng[2*v +: 2];
                end
            end
            rng = xorshift32(rng);
            run_formula(f, rng[1:0], rng[2]);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD = 10,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b0;  // power-on reset, active low.
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b1;
    end

endmodule
